// File: build.f
+incdir+sim
logic/lsu_pkg.sv
logic/lsu_req_queue.sv
logic/wb_encode_decode.sv
logic/lsu_wb_master.sv
logic/wb_sram_slave.sv
logic/wb_lsu_top.sv
sim/tb_wb_lsu.sv

// File: logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // data and address width of the core and the bus
    localparam int XLEN = 32;

    // one data word on the bus or on the response port
    typedef logic [XLEN-1:0] xword_t;

    // byte address as seen by the client
    typedef logic [XLEN-1:0] addr_t;

    // wishbone byte select, one bit per lane
    typedef logic [XLEN/8-1:0] bsel_t;

    // access size of a load or store
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } lsu_size_e;

    // bus master sequencing
    // respond is the cycle a load result is presented
    typedef enum logic [1:0] {
        st_idle    = 2'b00,
        st_bus     = 2'b01,
        st_respond = 2'b10
    } mst_state_e;

endpackage

`default_nettype wire

// File: logic/lsu_req_queue.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_req_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                 clk_i,
    input  wire                 rst_i,
    input  wire                 req_valid_i,
    input  wire                 req_we_i,
    input  lsu_pkg::lsu_size_e  req_size_i,
    input  wire                 req_unsigned_i,
    input  lsu_pkg::addr_t      req_addr_i,
    input  lsu_pkg::xword_t     req_wdata_i,
    input  wire                 pop_i,
    output logic                valid_o,
    output logic                we_o,
    output lsu_pkg::lsu_size_e  size_o,
    output logic                unsigned_o,
    output lsu_pkg::addr_t      addr_o,
    output lsu_pkg::xword_t     wdata_o,
    output logic                credit_o
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // request records, one entry per slot
    logic               we_mem   [QUEUE_DEPTH];
    lsu_pkg::lsu_size_e size_mem [QUEUE_DEPTH];
    logic               uns_mem  [QUEUE_DEPTH];
    lsu_pkg::addr_t     addr_mem [QUEUE_DEPTH];
    lsu_pkg::xword_t    data_mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full    = (count_q == CNT_W'(QUEUE_DEPTH));
    assign valid_o = (count_q != '0);
    assign do_pop  = pop_i && valid_o;
    // a full queue still takes a request when the head leaves this cycle
    // anything else while full means the client overran its credits, dropped
    assign do_push = req_valid_i && (!full || do_pop);

    // head of the buffer straight to the master
    assign we_o       = we_mem[rd_ptr_q];
    assign size_o     = size_mem[rd_ptr_q];
    assign unsigned_o = uns_mem[rd_ptr_q];
    assign addr_o     = addr_mem[rd_ptr_q];
    assign wdata_o    = data_mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            we_mem[wr_ptr_q]   <= req_we_i;
            size_mem[wr_ptr_q] <= req_size_i;
            uns_mem[wr_ptr_q]  <= req_unsigned_i;
            addr_mem[wr_ptr_q] <= req_addr_i;
            data_mem[wr_ptr_q] <= req_wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            // wrap pointers at the last slot, depth need not be a power of two
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (!do_push && do_pop) begin
                count_q <= count_q - 1'b1;
            end
            // one credit back per request that leaves
            credit_o <= do_pop;
        end
    end

endmodule

`default_nettype wire

// File: logic/lsu_wb_master.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_wb_master (
    input  wire                        clk_i,
    input  wire                        rst_i,
    input  wire                        q_valid_i,
    input  wire                        q_we_i,
    input  lsu_pkg::lsu_size_e         q_size_i,
    input  wire                        q_unsigned_i,
    input  lsu_pkg::addr_t             q_addr_i,
    input  lsu_pkg::xword_t            q_wdata_i,
    output logic                       q_pop_o,
    output logic                       wb_cyc_o,
    output logic                       wb_stb_o,
    output logic                       wb_we_o,
    output logic [lsu_pkg::XLEN-3:0]   wb_adr_o,
    output lsu_pkg::bsel_t             wb_sel_o,
    output lsu_pkg::xword_t            wb_dat_o,
    input  wire                        wb_ack_i,
    input  lsu_pkg::xword_t            wb_dat_i,
    output logic                       rsp_valid_o,
    output lsu_pkg::xword_t            rsp_rdata_o
);

    lsu_pkg::mst_state_e state_q;
    lsu_pkg::mst_state_e state_d;

    // request held for the whole bus cycle
    logic               req_we_q;
    lsu_pkg::lsu_size_e req_size_q;
    logic               req_uns_q;
    lsu_pkg::addr_t     req_addr_q;
    lsu_pkg::xword_t    req_wdata_q;

    lsu_pkg::bsel_t     sel;
    lsu_pkg::xword_t    load_decoded;
    lsu_pkg::xword_t    load_ext;
    logic               sign_bit;
    logic               can_pop;

    // the respond cycle is free for the next pop, keeping 3 clocks per access
    assign can_pop = (state_q == lsu_pkg::st_idle) || (state_q == lsu_pkg::st_respond);
    assign q_pop_o = can_pop && q_valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            lsu_pkg::st_idle,
            lsu_pkg::st_respond: begin
                state_d = q_valid_i ? lsu_pkg::st_bus : lsu_pkg::st_idle;
            end
            lsu_pkg::st_bus: begin
                // stores finish silently, loads report next cycle
                if (wb_ack_i) begin
                    state_d = req_we_q ? lsu_pkg::st_idle : lsu_pkg::st_respond;
                end
            end
            default: state_d = lsu_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= lsu_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (q_pop_o) begin
            req_we_q    <= q_we_i;
            req_size_q  <= q_size_i;
            req_uns_q   <= q_unsigned_i;
            req_addr_q  <= q_addr_i;
            req_wdata_q <= q_wdata_i;
        end
    end

    // byte select from size and low address bits
    always_comb begin
        case (req_size_q)
            lsu_pkg::size_byte: sel = 4'b0001 << req_addr_q[1:0];
            lsu_pkg::size_half: sel = req_addr_q[1] ? 4'b1100 : 4'b0011;
            default:            sel = 4'b1111;
        endcase
    end

    // strobe lasts exactly as long as the bus state
    assign wb_cyc_o = (state_q == lsu_pkg::st_bus);
    assign wb_stb_o = (state_q == lsu_pkg::st_bus);
    assign wb_we_o  = req_we_q;
    assign wb_adr_o = req_addr_q[lsu_pkg::XLEN-1:2];
    assign wb_sel_o = sel;

    wb_encode_decode u_lanes (
        .sel_i              (sel),
        .master_dat_i       (wb_dat_i),
        .unencoded_output_i (req_wdata_q),
        .input_decoded_o    (load_decoded),
        .master_dat_o       (wb_dat_o)
    );

    // decoded data already sits at bit 0, only the upper bits need filling
    always_comb begin
        case (req_size_q)
            lsu_pkg::size_byte: begin
                sign_bit = !req_uns_q && load_decoded[7];
                load_ext = {{24{sign_bit}}, load_decoded[7:0]};
            end
            lsu_pkg::size_half: begin
                sign_bit = !req_uns_q && load_decoded[15];
                load_ext = {{16{sign_bit}}, load_decoded[15:0]};
            end
            default: begin
                sign_bit = 1'b0;
                load_ext = load_decoded;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == lsu_pkg::st_bus) && wb_ack_i && !req_we_q) begin
            rsp_rdata_o <= load_ext;
        end
    end

    // only loads pass through respond
    assign rsp_valid_o = (state_q == lsu_pkg::st_respond);

endmodule

`default_nettype wire

// File: logic/wb_encode_decode.sv
`timescale 1ns/100ps
`default_nettype none

module wb_encode_decode (
    input  lsu_pkg::bsel_t  sel_i,
    input  lsu_pkg::xword_t master_dat_i,
    input  lsu_pkg::xword_t unencoded_output_i,
    output lsu_pkg::xword_t input_decoded_o,
    output lsu_pkg::xword_t master_dat_o
);

    // access width recovered from the select pattern
    logic       half_access;
    logic       byte_access;
    // lane offset, bit 0 picks the odd byte, bit 1 the upper half
    logic [1:0] lane;
    logic [15:0] load_half;
    logic [7:0]  load_byte;

    assign half_access = (sel_i == 4'b0011) || (sel_i == 4'b1100);
    assign byte_access = !half_access && (sel_i != 4'b1111);

    assign lane[0] = (sel_i == 4'b0010) || (sel_i == 4'b1000);
    assign lane[1] = (sel_i == 4'b0100) || (sel_i == 4'b1000) || (sel_i == 4'b1100);

    // load path, pick the half first and then the byte inside it
    assign load_half = lane[1] ? master_dat_i[31:16] : master_dat_i[15:0];
    assign load_byte = lane[0] ? load_half[15:8] : load_half[7:0];

    assign input_decoded_o = byte_access ? {24'b0, load_byte} :
                             half_access ? {16'b0, load_half} :
                                           master_dat_i;

    // store path, replicate the low byte or half onto the addressed lanes
    // lanes outside the select carry don't care data
    assign master_dat_o[7:0]   = unencoded_output_i[7:0];
    assign master_dat_o[15:8]  = lane[0] ? unencoded_output_i[7:0] : unencoded_output_i[15:8];
    assign master_dat_o[23:16] = lane[1] ? unencoded_output_i[7:0] : unencoded_output_i[23:16];
    assign master_dat_o[31:24] = lane[0] ? unencoded_output_i[7:0] :
                                 lane[1] ? unencoded_output_i[15:8] :
                                           unencoded_output_i[31:24];

endmodule

`default_nettype wire

// File: logic/wb_lsu_top.sv
`timescale 1ns/100ps
`default_nettype none

module wb_lsu_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int MEM_WORDS   = 256
) (
    input  wire                 clk_i,
    input  wire                 rst_i,
    input  wire                 req_valid_i,
    input  wire                 req_we_i,
    input  lsu_pkg::lsu_size_e  req_size_i,
    input  wire                 req_unsigned_i,
    input  lsu_pkg::addr_t      req_addr_i,
    input  lsu_pkg::xword_t     req_wdata_i,
    output logic                credit_o,
    output logic                rsp_valid_o,
    output lsu_pkg::xword_t     rsp_rdata_o
);

    // queue head towards the master
    logic               q_valid;
    logic               q_pop;
    logic               q_we;
    lsu_pkg::lsu_size_e q_size;
    logic               q_unsigned;
    lsu_pkg::addr_t     q_addr;
    lsu_pkg::xword_t    q_wdata;

    // classic wishbone between master and memory
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [lsu_pkg::XLEN-3:0] wb_adr;
    lsu_pkg::bsel_t           wb_sel;
    lsu_pkg::xword_t          wb_dat_w;
    logic                     wb_ack;
    lsu_pkg::xword_t          wb_dat_r;

    // requests wait here while one bus cycle is in progress
    lsu_req_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .req_valid_i    (req_valid_i),
        .req_we_i       (req_we_i),
        .req_size_i     (req_size_i),
        .req_unsigned_i (req_unsigned_i),
        .req_addr_i     (req_addr_i),
        .req_wdata_i    (req_wdata_i),
        .pop_i          (q_pop),
        .valid_o        (q_valid),
        .we_o           (q_we),
        .size_o         (q_size),
        .unsigned_o     (q_unsigned),
        .addr_o         (q_addr),
        .wdata_o        (q_wdata),
        .credit_o       (credit_o)
    );

    // mst_state_e walks idle, bus and respond for each request
    lsu_wb_master u_master (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .q_valid_i    (q_valid),
        .q_we_i       (q_we),
        .q_size_i     (q_size),
        .q_unsigned_i (q_unsigned),
        .q_addr_i     (q_addr),
        .q_wdata_i    (q_wdata),
        .q_pop_o      (q_pop),
        .wb_cyc_o     (wb_cyc),
        .wb_stb_o     (wb_stb),
        .wb_we_o      (wb_we),
        .wb_adr_o     (wb_adr),
        .wb_sel_o     (wb_sel),
        .wb_dat_o     (wb_dat_w),
        .wb_ack_i     (wb_ack),
        .wb_dat_i     (wb_dat_r),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_rdata_o  (rsp_rdata_o)
    );

    wb_sram_slave #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_sel_i (wb_sel),
        .wb_dat_i (wb_dat_w),
        .wb_ack_o (wb_ack),
        .wb_dat_o (wb_dat_r)
    );

endmodule

`default_nettype wire

// File: logic/wb_sram_slave.sv
`timescale 1ns/100ps
`default_nettype none

module wb_sram_slave #(
    parameter int MEM_WORDS = 256
) (
    input  wire                        clk_i,
    input  wire                        rst_i,
    input  wire                        wb_cyc_i,
    input  wire                        wb_stb_i,
    input  wire                        wb_we_i,
    input  wire [lsu_pkg::XLEN-3:0]    wb_adr_i,
    input  lsu_pkg::bsel_t             wb_sel_i,
    input  lsu_pkg::xword_t            wb_dat_i,
    output logic                       wb_ack_o,
    output lsu_pkg::xword_t            wb_dat_o
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    lsu_pkg::xword_t mem [MEM_WORDS];

    logic             req;
    logic             served_q;
    logic             ack_d;
    logic [IDX_W-1:0] idx;

    assign req = wb_cyc_i && wb_stb_i;
    // upper address bits alias onto the array
    assign idx = wb_adr_i[IDX_W-1:0];
    // one ack per strobe, even if the master keeps it high
    assign ack_d = req && !wb_ack_o && !served_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
            served_q <= 1'b0;
        end else begin
            wb_ack_o <= ack_d;
            // remember a finished access until the strobe goes away
            served_q <= req && (served_q || wb_ack_o);
        end
    end

    // writes touch only selected lanes, reads return the full word
    always_ff @(posedge clk_i) begin
        if (ack_d) begin
            wb_dat_o <= mem[idx];
            if (wb_we_i) begin
                for (int i = 0; i < lsu_pkg::XLEN / 8; i++) begin
                    if (wb_sel_i[i]) begin
                        mem[idx][8*i +: 8] <= wb_dat_i[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# compile and run the load/store unit testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -Wno-fatal --top-module tb_wb_lsu \
    -f build.f --Mdir obj_dir -o tb_wb_lsu
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/tb_wb_lsu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
    exit 0
fi
exit 1

// File: sim/tb_wb_lsu_model.svh
`ifndef TB_WB_LSU_MODEL_SVH
`define TB_WB_LSU_MODEL_SVH

// byte-addressed copy of what the memory should hold
logic [7:0] shadow_mem [4*MEM_WORDS];

// galois lfsr state, 16 bit, taps for a maximal sequence
logic [15:0] lfsr_q = 16'd39878;

// one lfsr step, returns the bit shifted out
function automatic logic lfsr_step();
    logic out_bit;
    out_bit = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out_bit) begin
        lfsr_q = lfsr_q ^ 16'hB400;
    end
    return out_bit;
endfunction

// n random bits, one lfsr step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsr_step()};
    end
    return r;
endfunction

function automatic int size_bytes(input lsu_pkg::lsu_size_e s);
    case (s)
        lsu_pkg::size_byte: return 1;
        lsu_pkg::size_half: return 2;
        default:            return 4;
    endcase
endfunction

// prefill value, every address bit moves the result
function automatic lsu_pkg::xword_t fill_word(input int idx);
    return (lsu_pkg::xword_t'(idx) * 32'h9E37_79B1) ^ 32'hC3A5_0F1E;
endfunction

// little endian: byte i of the data lands at address a + i
function automatic void shadow_store(input lsu_pkg::addr_t a, input lsu_pkg::lsu_size_e s,
                                     input lsu_pkg::xword_t d);
    int n;
    n = size_bytes(s);
    for (int i = 0; i < n; i++) begin
        shadow_mem[(int'(a) + i) % (4*MEM_WORDS)] = d[8*i +: 8];
    end
endfunction

// value a load must return, sign filled unless unsigned
function automatic lsu_pkg::xword_t expected_load(input lsu_pkg::addr_t a,
                                                  input lsu_pkg::lsu_size_e s, input logic uns);
    lsu_pkg::xword_t v;
    int n;
    n = size_bytes(s);
    v = '0;
    for (int i = 0; i < n; i++) begin
        v[8*i +: 8] = shadow_mem[(int'(a) + i) % (4*MEM_WORDS)];
    end
    if (!uns && n == 1 && v[7]) begin
        v[31:8] = '1;
    end
    if (!uns && n == 2 && v[15]) begin
        v[31:16] = '1;
    end
    return v;
endfunction

`endif

// File: sim/tb_wb_lsu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_wb_lsu;

    localparam int QUEUE_DEPTH = 4;
    localparam int MEM_WORDS   = 256;
    localparam int IDX_W       = $clog2(MEM_WORDS);
    localparam int N_WORD      = 16;
    localparam int N_LANE      = 24;
    localparam int N_RAND      = 200;
    // prefill, word round trip, lane tests, random mix
    localparam int N_REQ       = MEM_WORDS + N_WORD + N_LANE + N_RAND;
    localparam int CYCLE_LIMIT = 10 * N_REQ * 3 + 200;
    // worst-case drain of a full queue plus the access in flight at 3 clocks each
    localparam int DRAIN_LIMIT = (QUEUE_DEPTH + 2) * 3;

    logic               clk_i;
    logic               rst_i;
    logic               req_valid_i;
    logic               req_we_i;
    lsu_pkg::lsu_size_e req_size_i;
    logic               req_unsigned_i;
    lsu_pkg::addr_t     req_addr_i;
    lsu_pkg::xword_t    req_wdata_i;
    logic               credit_o;
    logic               rsp_valid_o;
    lsu_pkg::xword_t    rsp_rdata_o;

    // client side bookkeeping
    int credits = QUEUE_DEPTH;
    int pulses = 0;
    int sent_count = 0;
    int load_count = 0;
    int rsp_count = 0;
    int errors = 0;
    int cycles = 0;
    lsu_pkg::xword_t exp_q [$];
    lsu_pkg::addr_t  word_addr [8];

    `include "tb_wb_lsu_model.svh"

    wb_lsu_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .MEM_WORDS   (MEM_WORDS)
    ) u_dut (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .req_valid_i    (req_valid_i),
        .req_we_i       (req_we_i),
        .req_size_i     (req_size_i),
        .req_unsigned_i (req_unsigned_i),
        .req_addr_i     (req_addr_i),
        .req_wdata_i    (req_wdata_i),
        .credit_o       (credit_o),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_rdata_o    (rsp_rdata_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic abort_run(input string msg);
        errors++;
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_word(input lsu_pkg::xword_t actual, input lsu_pkg::xword_t expected,
                              input string what);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic check_count(input integer actual, input integer expected, input string what);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH at %0t: %s got %0d expected %0d",
                                $time, what, actual, expected));
        end
    endtask

    // issue one request once a credit is held
    // inputs move 1 ns after the edge
    task automatic send_req(input logic we, input lsu_pkg::lsu_size_e size, input logic uns,
                            input lsu_pkg::addr_t addr, input lsu_pkg::xword_t wdata);
        @(posedge clk_i);
        #1;
        req_valid_i = 1'b0;
        while (credits == 0) begin
            @(posedge clk_i);
            #1;
        end
        req_valid_i    = 1'b1;
        req_we_i       = we;
        req_size_i     = size;
        req_unsigned_i = uns;
        req_addr_i     = addr;
        req_wdata_i    = wdata;
        credits--;
        sent_count++;
        // the model sees requests in issue order like the bus
        if (we) begin
            shadow_store(addr, size, wdata);
        end else begin
            exp_q.push_back(expected_load(addr, size, uns));
            load_count++;
        end
    endtask

    // stop issuing and wait until all credits are back and all loads answered
    // gives up after the drain time of a full queue
    task automatic wait_drain();
        int waited;
        waited = 0;
        @(posedge clk_i);
        #1;
        req_valid_i = 1'b0;
        while ((credits != QUEUE_DEPTH || exp_q.size() != 0) && waited < DRAIN_LIMIT) begin
            @(posedge clk_i);
            #1;
            waited++;
        end
        repeat (3) @(posedge clk_i);
        #1;
    endtask

    // one credit back per pulse sampled mid-cycle
    always @(negedge clk_i) begin
        if (!rst_i && credit_o === 1'b1) begin
            credits++;
            pulses++;
            if (credits > QUEUE_DEPTH) begin
                abort_run("credit counter rose above the queue depth");
            end
        end
    end

    // every response takes the oldest expected load value
    always @(negedge clk_i) begin
        if (!rst_i && rsp_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                abort_run("response arrived with no load outstanding");
            end else begin
                check_word(rsp_rdata_o, exp_q.pop_front(), "load data");
            end
            rsp_count++;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            abort_run($sformatf("timeout, run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        lsu_pkg::xword_t d;
        lsu_pkg::addr_t  a;
        lsu_pkg::addr_t  ra;
        lsu_pkg::lsu_size_e sz;
        logic [31:0] r;
        rst_i          = 1'b1;
        req_valid_i    = 1'b0;
        req_we_i       = 1'b0;
        req_size_i     = lsu_pkg::size_word;
        req_unsigned_i = 1'b0;
        req_addr_i     = '0;
        req_wdata_i    = '0;

        // nothing may pulse in reset or before the first request
        repeat (4) begin
            @(posedge clk_i);
            #1;
            check_count(credit_o, 0, "credit_o in reset");
            check_count(rsp_valid_o, 0, "rsp_valid_o in reset");
        end
        rst_i = 1'b0;
        repeat (3) begin
            @(posedge clk_i);
            #1;
            check_count(credit_o, 0, "credit_o before first request");
            check_count(rsp_valid_o, 0, "rsp_valid_o before first request");
        end

        // prefill as a full-rate store stream that runs on credits alone
        for (int w = 0; w < MEM_WORDS; w++) begin
            send_req(1'b1, lsu_pkg::size_word, 1'b0, lsu_pkg::addr_t'(w) << 2, fill_word(w));
        end
        wait_drain();
        check_count(pulses, sent_count, "credit pulses after prefill");
        check_count(credits, QUEUE_DEPTH, "credits after prefill");

        // word round trip
        for (int i = 0; i < 8; i++) begin
            word_addr[i] = rand_bits(IDX_W) << 2;
            send_req(1'b1, lsu_pkg::size_word, 1'b0, word_addr[i], rand_bits(32));
        end
        for (int i = 0; i < 8; i++) begin
            send_req(1'b0, lsu_pkg::size_word, 1'b0, word_addr[i], '0);
        end

        // byte lanes with alternating sign bit so both extensions show up
        for (int b = 0; b < 4; b++) begin
            a = lsu_pkg::addr_t'((16 + b) * 4);
            d = rand_bits(32);
            d[7] = b[0];
            send_req(1'b1, lsu_pkg::size_byte, 1'b0, a + b, d);
            send_req(1'b0, lsu_pkg::size_word, 1'b0, a, '0);
            send_req(1'b0, lsu_pkg::size_byte, 1'b0, a + b, '0);
            send_req(1'b0, lsu_pkg::size_byte, 1'b1, a + b, '0);
        end
        // halfword lanes
        for (int h = 0; h < 2; h++) begin
            a = lsu_pkg::addr_t'((24 + h) * 4);
            d = rand_bits(32);
            d[15] = ~h[0];
            send_req(1'b1, lsu_pkg::size_half, 1'b0, a + 2 * h, d);
            send_req(1'b0, lsu_pkg::size_word, 1'b0, a, '0);
            send_req(1'b0, lsu_pkg::size_half, 1'b0, a + 2 * h, '0);
            send_req(1'b0, lsu_pkg::size_half, 1'b1, a + 2 * h, '0);
        end
        wait_drain();

        // random mix of loads and stores aligned per size
        for (int i = 0; i < N_RAND; i++) begin
            r = rand_bits(2);
            case (r[1:0])
                2'd0:    sz = lsu_pkg::size_byte;
                2'd1:    sz = lsu_pkg::size_half;
                default: sz = lsu_pkg::size_word;
            endcase
            ra = rand_bits(IDX_W) << 2;
            if (sz == lsu_pkg::size_byte) begin
                ra = ra | rand_bits(2);
            end else if (sz == lsu_pkg::size_half) begin
                ra = ra | (rand_bits(1) << 1);
            end
            r = rand_bits(2);
            send_req(r[0], sz, r[1], ra, rand_bits(32));
        end
        wait_drain();

        check_count(pulses, sent_count, "credit pulses");
        check_count(credits, QUEUE_DEPTH, "credits after drain");
        check_count(rsp_count, load_count, "responses");

        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
